// ==== common/ntt_alu_pkg.sv ====
package ntt_alu_pkg;

  // polynomial length is at most 2**MAX_LOGN coefficients
  localparam int MAX_LOGN = 6;

  // coefficient and modulus width
  localparam int LOGQ = 16;

  // multiplier bits handled by one chain stage
  localparam int MUL_BITS = 4;

  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_CONF = 2'd1,
    OP_ADD  = 2'd2,
    OP_MULT = 2'd3
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2
  } seq_state_e;

  // read request from the sequencer, one per coefficient
  typedef struct packed {
    logic                valid;
    logic                is_mult;
    logic [MAX_LOGN-1:0] addr;
  } mem_req_t;

  // item travelling down the multiply chain
  typedef struct packed {
    logic                valid;
    logic                is_mult;
    logic [MAX_LOGN-1:0] addr;
    logic [LOGQ-1:0]     a;
    // multiplier bits not yet consumed, next bit at the MSB
    logic [LOGQ-1:0]     b_rem;
    // partial product, always below q
    logic [LOGQ-1:0]     acc;
  } mul_token_t;

  // result write into poly 1
  typedef struct packed {
    logic                valid;
    logic [MAX_LOGN-1:0] addr;
    logic [LOGQ-1:0]     data;
  } mem_wr_t;

endpackage

// ==== design/poly_mem.sv ====
module poly_mem
  import ntt_alu_pkg::*;
#(
  parameter int MAX_LOGN = ntt_alu_pkg::MAX_LOGN,
  parameter int LOGQ     = ntt_alu_pkg::LOGQ
) (
  input  logic                clk,
  input  logic                rst_n,
  input  mem_req_t            req,
  input  mem_wr_t             wr,
  input  logic                host_wr,
  input  logic                host_rd,
  input  logic                host_poly,
  input  logic [MAX_LOGN-1:0] host_addr,
  input  logic [LOGQ-1:0]     host_data,
  output logic                host_rd_valid,
  output logic [LOGQ-1:0]     host_rd_data,
  output mul_token_t          token
);

  localparam int DEPTH = 2 ** MAX_LOGN;

  // poly 0 holds a, poly 1 holds b and receives the result
  logic [LOGQ-1:0] mem0 [DEPTH];
  logic [LOGQ-1:0] mem1 [DEPTH];

  always_ff @(posedge clk) begin
    if (host_wr && !host_poly) begin
      mem0[host_addr] <= host_data;
    end
    // result writeback owns poly 1 while an op runs
    if (wr.valid) begin
      mem1[wr.addr] <= wr.data;
    end else if (host_wr && host_poly) begin
      mem1[host_addr] <= host_data;
    end
  end

  // both operands read at the request address, acc starts at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      token <= '0;
    end else begin
      token.valid   <= req.valid;
      token.is_mult <= req.is_mult;
      token.addr    <= req.addr;
      token.a       <= mem0[req.addr];
      token.b_rem   <= mem1[req.addr];
      token.acc     <= '0;
    end
  end

  // host readback, one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_rd_valid <= 1'b0;
    end else begin
      host_rd_valid <= host_rd;
    end
  end

  always_ff @(posedge clk) begin
    host_rd_data <= host_poly ? mem1[host_addr] : mem0[host_addr];
  end

endmodule

// ==== alu_core/alu_sequencer.sv ====
module alu_sequencer
  import ntt_alu_pkg::*;
#(
  parameter int MAX_LOGN   = ntt_alu_pkg::MAX_LOGN,
  parameter int LOGQ       = ntt_alu_pkg::LOGQ,
  parameter int NUM_STAGES = ntt_alu_pkg::LOGQ / ntt_alu_pkg::MUL_BITS
) (
  input  logic              clk,
  input  logic              rst_n,
  input  alu_op_e           op,
  input  logic [MAX_LOGN:0] cfg_logn,
  input  logic [LOGQ-1:0]   cfg_q,
  output logic [LOGQ-1:0]   q,
  output mem_req_t          req,
  output logic              done
);

  // request to writeback: memory, stages, writeback register
  localparam int PIPE_LATENCY = NUM_STAGES + 2;
  localparam int DRAIN_W      = $clog2(PIPE_LATENCY + 1);
  localparam int CNT_W        = (MAX_LOGN > DRAIN_W) ? MAX_LOGN : DRAIN_W;

  seq_state_e          state;
  logic [MAX_LOGN:0]   logn_q;
  logic                is_mult_q;
  logic [CNT_W-1:0]    cnt;
  logic [MAX_LOGN-1:0] last_addr;

  assign last_addr = MAX_LOGN'((1 << logn_q) - 1);
  assign done      = (state == ST_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      logn_q    <= '0;
      q         <= '0;
      is_mult_q <= 1'b0;
      cnt       <= '0;
      req       <= '0;
    end else begin
      req <= '0;
      case (state)
        ST_IDLE: begin
          cnt <= '0;
          case (op)
            OP_CONF: begin
              logn_q <= cfg_logn;
              q      <= cfg_q;
              // preloaded counter leaves drain on the next edge
              cnt    <= CNT_W'(PIPE_LATENCY);
              state  <= ST_DRAIN;
            end
            OP_ADD, OP_MULT: begin
              is_mult_q <= (op == OP_MULT);
              state     <= ST_RUN;
            end
            default: begin
            end
          endcase
        end
        ST_RUN: begin
          req.valid   <= 1'b1;
          req.is_mult <= is_mult_q;
          req.addr    <= cnt[MAX_LOGN-1:0];
          if (cnt == CNT_W'(last_addr)) begin
            cnt   <= '0;
            state <= ST_DRAIN;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_DRAIN: begin
          // wait for the last coefficient to reach poly 1
          if (cnt == CNT_W'(PIPE_LATENCY)) begin
            cnt   <= '0;
            state <= ST_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== alu_core/mod_mul_stage.sv ====
module mod_mul_stage
  import ntt_alu_pkg::*;
#(
  parameter int LOGQ     = ntt_alu_pkg::LOGQ,
  parameter int MUL_BITS = ntt_alu_pkg::MUL_BITS
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [LOGQ-1:0] q,
  input  mul_token_t      token_in,
  output mul_token_t      token_out
);

  // 2*acc + a stays below 3q, so two spare bits are enough
  logic [LOGQ+1:0] t;
  logic [LOGQ-1:0] acc_v;
  logic [LOGQ-1:0] b_v;

  always_comb begin
    acc_v = token_in.acc;
    b_v   = token_in.b_rem;
    t     = '0;
    for (int i = 0; i < MUL_BITS; i++) begin
      // msb first: acc = 2*acc + bit*a, then back below q
      t = {2'b00, acc_v} << 1;
      if (b_v[LOGQ-1]) begin
        t = t + {2'b00, token_in.a};
      end
      if (t >= {2'b00, q}) begin
        t = t - {2'b00, q};
      end
      if (t >= {2'b00, q}) begin
        t = t - {2'b00, q};
      end
      acc_v = t[LOGQ-1:0];
      b_v   = b_v << 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      token_out <= '0;
    end else begin
      token_out <= token_in;
      // add tokens keep b unshifted for the writeback sum
      if (token_in.is_mult) begin
        token_out.acc   <= acc_v;
        token_out.b_rem <= b_v;
      end
    end
  end

endmodule

// ==== alu_core/alu_writeback.sv ====
module alu_writeback
  import ntt_alu_pkg::*;
#(
  parameter int LOGQ = ntt_alu_pkg::LOGQ
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [LOGQ-1:0] q,
  input  mul_token_t      token,
  output mem_wr_t         wr
);

  logic [LOGQ:0]   sum;
  logic [LOGQ-1:0] add_res;
  logic [LOGQ-1:0] result;

  // a + b below 2q, one conditional subtract is enough
  always_comb begin
    sum     = {1'b0, token.a} + {1'b0, token.b_rem};
    add_res = sum[LOGQ-1:0];
    if (sum >= {1'b0, q}) begin
      add_res = LOGQ'(sum - {1'b0, q});
    end
    result = token.is_mult ? token.acc : add_res;
  end

  // result always lands in poly 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr <= '0;
    end else begin
      wr.valid <= token.valid;
      wr.addr  <= token.addr;
      wr.data  <= result;
    end
  end

endmodule

// ==== design/ntt_alu_top.sv ====
module ntt_alu_top
  import ntt_alu_pkg::*;
#(
  parameter int MAX_LOGN = ntt_alu_pkg::MAX_LOGN,
  parameter int LOGQ     = ntt_alu_pkg::LOGQ,
  parameter int MUL_BITS = ntt_alu_pkg::MUL_BITS
) (
  input  logic                clk,
  input  logic                rst_n,
  input  alu_op_e             op,
  input  logic [MAX_LOGN:0]   cfg_logn,
  input  logic [LOGQ-1:0]     cfg_q,
  input  logic                host_wr,
  input  logic                host_rd,
  input  logic                host_poly,
  input  logic [MAX_LOGN-1:0] host_addr,
  input  logic [LOGQ-1:0]     host_data,
  output logic                host_rd_valid,
  output logic [LOGQ-1:0]     host_rd_data,
  output logic                done
);

  localparam int NUM_STAGES = LOGQ / MUL_BITS;

  logic [LOGQ-1:0] q;
  mem_req_t        req;
  mem_wr_t         wr;
  // chain[0] comes from the memory, chain[NUM_STAGES] goes to writeback
  mul_token_t      chain [NUM_STAGES+1];

  alu_sequencer #(
    .MAX_LOGN  (MAX_LOGN),
    .LOGQ      (LOGQ),
    .NUM_STAGES(NUM_STAGES)
  ) u_alu_sequencer (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (op),
    .cfg_logn(cfg_logn),
    .cfg_q   (cfg_q),
    .q       (q),
    .req     (req),
    .done    (done)
  );

  poly_mem #(
    .MAX_LOGN(MAX_LOGN),
    .LOGQ    (LOGQ)
  ) u_poly_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .wr           (wr),
    .host_wr      (host_wr),
    .host_rd      (host_rd),
    .host_poly    (host_poly),
    .host_addr    (host_addr),
    .host_data    (host_data),
    .host_rd_valid(host_rd_valid),
    .host_rd_data (host_rd_data),
    .token        (chain[0])
  );

  for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
    mod_mul_stage #(
      .LOGQ    (LOGQ),
      .MUL_BITS(MUL_BITS)
    ) u_mod_mul_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .q        (q),
      .token_in (chain[g]),
      .token_out(chain[g+1])
    );
  end

  alu_writeback #(
    .LOGQ(LOGQ)
  ) u_alu_writeback (
    .clk  (clk),
    .rst_n(rst_n),
    .q    (q),
    .token(chain[NUM_STAGES]),
    .wr   (wr)
  );

endmodule

// ==== testbench/ntt_alu_tb.sv ====
module ntt_alu_tb
  import ntt_alu_pkg::*;
();

  localparam int NUM_STAGES   = LOGQ / MUL_BITS;
  localparam int PIPE_LATENCY = NUM_STAGES + 2;
  localparam int DEPTH        = 2 ** MAX_LOGN;
  // two full-length ops, one short op and two configs
  localparam int OP_CYCLES    = 2 * (DEPTH + PIPE_LATENCY + 1) + (8 + PIPE_LATENCY + 1) + 2;
  // three loads and three readbacks of both polynomials
  localparam int HOST_CYCLES  = 6 * 2 * DEPTH + 50;
  localparam int MAX_CYCLES   = 2 * OP_CYCLES + HOST_CYCLES;

  logic                clk;
  logic                rst_n;
  alu_op_e             op;
  logic [MAX_LOGN:0]   cfg_logn;
  logic [LOGQ-1:0]     cfg_q;
  logic                host_wr;
  logic                host_rd;
  logic                host_poly;
  logic [MAX_LOGN-1:0] host_addr;
  logic [LOGQ-1:0]     host_data;
  logic                host_rd_valid;
  logic [LOGQ-1:0]     host_rd_data;
  logic                done;

  // testbench copy of both polynomials
  logic [LOGQ-1:0] pa [DEPTH];
  logic [LOGQ-1:0] pb [DEPTH];
  logic [LOGQ-1:0] q_cur;
  logic [31:0]     lfsr;
  logic [LOGQ-1:0] exp_data [$];
  int              exp_tag [$];
  logic [LOGQ-1:0] want_data;
  int              want_tag;
  int              errors = 0;
  int              checks = 0;
  int              cycle_cnt = 0;

  ntt_alu_top u_ntt_alu_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // readback responses compared mid-cycle against the queued values
  always @(negedge clk) begin
    if (host_rd_valid) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("read response at time %0t without a read request", $time);
      end else begin
        want_data = exp_data.pop_front();
        want_tag  = exp_tag.pop_front();
        checks++;
        if (host_rd_data !== want_data) begin
          errors++;
          $display("ERR %0t: poly%0d[%0d] read %h, expected %h", $time,
                   want_tag / DEPTH, want_tag % DEPTH, host_rd_data, want_data);
        end
      end
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [LOGQ-1:0] ref_op(input logic [LOGQ-1:0] a, input logic [LOGQ-1:0] b,
                                             input logic [LOGQ-1:0] qv, input logic is_mult);
    longint unsigned r;
    r = a;
    if (is_mult) begin
      r = r * b;
    end else begin
      r = r + b;
    end
    return LOGQ'(r % qv);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic write_coef(input logic poly, input int addr, input logic [LOGQ-1:0] data);
    host_wr   = 1'b1;
    host_poly = poly;
    host_addr = addr[MAX_LOGN-1:0];
    host_data = data;
    step();
    host_wr = 1'b0;
  endtask

  task automatic read_coef(input logic poly, input int addr, input logic [LOGQ-1:0] want);
    host_rd   = 1'b1;
    host_poly = poly;
    host_addr = addr[MAX_LOGN-1:0];
    exp_data.push_back(want);
    exp_tag.push_back(int'(poly) * DEPTH + addr);
    step();
    host_rd = 1'b0;
  endtask

  task automatic load_polys(input logic near_max);
    for (int k = 0; k < DEPTH; k++) begin
      if (near_max) begin
        pa[k] = q_cur - LOGQ'(1) - LOGQ'(rand_bits(6));
        pb[k] = q_cur - LOGQ'(1) - LOGQ'(rand_bits(6));
      end else begin
        pa[k] = LOGQ'(rand_bits(LOGQ) % 32'(q_cur));
        pb[k] = LOGQ'(rand_bits(LOGQ) % 32'(q_cur));
      end
      write_coef(1'b0, k, pa[k]);
      write_coef(1'b1, k, pb[k]);
    end
  endtask

  task automatic verify_all();
    for (int k = 0; k < DEPTH; k++) begin
      read_coef(1'b0, k, pa[k]);
      read_coef(1'b1, k, pb[k]);
    end
  endtask

  // strobes an op plus an optional busy op and times done
  task automatic run_op(input alu_op_e code, input int logn, input alu_op_e busy_op);
    int low_cycles;
    int want;
    low_cycles = 0;
    want       = (code == OP_CONF) ? 1 : (1 << logn) + PIPE_LATENCY + 1;
    op         = code;
    // config inputs carry meaning only together with OP_CONF
    if (code == OP_CONF) begin
      cfg_logn = logn[MAX_LOGN:0];
      cfg_q    = q_cur;
    end
    step();
    cfg_logn = '0;
    cfg_q    = '0;
    while (!done) begin
      low_cycles++;
      op = (low_cycles == 2) ? busy_op : OP_NONE;
      step();
    end
    op = OP_NONE;
    checks++;
    if (low_cycles != want) begin
      errors++;
      $display("ERR %0t: done low for %0d cycles, expected %0d", $time, low_cycles, want);
    end
  endtask

  task automatic apply_ref(input int logn, input logic is_mult);
    for (int k = 0; k < (1 << logn); k++) begin
      pb[k] = ref_op(pa[k], pb[k], q_cur, is_mult);
    end
  endtask

  initial begin
    lfsr      = 32'h670d;
    rst_n     = 1'b0;
    op        = OP_NONE;
    cfg_logn  = '0;
    cfg_q     = '0;
    host_wr   = 1'b0;
    host_rd   = 1'b0;
    host_poly = 1'b0;
    host_addr = '0;
    host_data = '0;
    q_cur     = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    checks++;
    if (done !== 1'b1 || host_rd_valid !== 1'b0) begin
      errors++;
      $display("ERR %0t: done %b host_rd_valid %b after reset", $time, done, host_rd_valid);
    end
    // single write and read with a one cycle response
    write_coef(1'b0, 5, 16'h1234);
    read_coef(1'b0, 5, 16'h1234);
    checks++;
    if (host_rd_valid !== 1'b1) begin
      errors++;
      $display("ERR %0t: host_rd_valid low one cycle after the read", $time);
    end
    step();
    checks++;
    if (host_rd_valid !== 1'b0) begin
      errors++;
      $display("ERR %0t: host_rd_valid high for more than one cycle", $time);
    end
    // full length add then mult with operands close to q
    q_cur = 16'hfff1;
    run_op(OP_CONF, 6, OP_NONE);
    load_polys(1'b0);
    run_op(OP_ADD, 6, OP_MULT);
    apply_ref(6, 1'b0);
    verify_all();
    load_polys(1'b1);
    run_op(OP_MULT, 6, OP_ADD);
    apply_ref(6, 1'b1);
    verify_all();
    // 8 coefficients only so the rest of poly 1 keeps its values
    q_cur = 16'h3001;
    run_op(OP_CONF, 3, OP_NONE);
    load_polys(1'b0);
    run_op(OP_MULT, 3, OP_MULT);
    apply_ref(3, 1'b1);
    verify_all();
    step();
    step();
    if (exp_data.size() != 0) begin
      errors++;
      $display("%0d read responses never arrived", exp_data.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/ntt_alu_pkg.sv
design/poly_mem.sv
alu_core/alu_sequencer.sv
alu_core/mod_mul_stage.sv
alu_core/alu_writeback.sv
design/ntt_alu_top.sv
testbench/ntt_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sources.f --top-module ntt_alu_tb -o ntt_alu_sim

out=$(./obj_dir/ntt_alu_sim)
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
  exit 0
fi
exit 1
